// File: axi_write_xbar.f
+incdir+logic
logic/axi_pkg.sv
logic/xbar_route_pkg.sv
logic/xbar_arbiter.sv
logic/aw_route.sv
logic/w_route.sv
logic/b_route.sv
logic/axi_write_xbar.sv
bench/tb_axi_write_xbar.sv

// File: run_sim.sh
#!/bin/sh
# build and run the write crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f axi_write_xbar.f \
    --top-module tb_axi_write_xbar > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_axi_write_xbar > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

// File: bench/tb_axi_write_xbar.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defs.svh"

module tb_axi_write_xbar
    import axi_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TEST_NUM   = 5;

    logic                                   clk = 1'b0;
    logic                                   rst;
    logic       [`XBAR_MASTER_NUM-1:0]      m_awvalid;
    logic       [`XBAR_MASTER_NUM-1:0]      m_awready;
    id_t        [`XBAR_MASTER_NUM-1:0]      m_awid;
    addr_t      [`XBAR_MASTER_NUM-1:0]      m_awaddr;
    len_t       [`XBAR_MASTER_NUM-1:0]      m_awlen;
    logic       [`XBAR_MASTER_NUM-1:0]      m_wvalid;
    logic       [`XBAR_MASTER_NUM-1:0]      m_wready;
    data_t      [`XBAR_MASTER_NUM-1:0]      m_wdata;
    strb_t      [`XBAR_MASTER_NUM-1:0]      m_wstrb;
    logic       [`XBAR_MASTER_NUM-1:0]      m_wlast;
    logic       [`XBAR_MASTER_NUM-1:0]      m_bvalid;
    logic       [`XBAR_MASTER_NUM-1:0]      m_bready;
    id_t        [`XBAR_MASTER_NUM-1:0]      m_bid;
    resp_t      [`XBAR_MASTER_NUM-1:0]      m_bresp;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_awvalid;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_awready;
    ext_id_t    [`XBAR_SLAVE_NUM-1:0]       s_awid;
    addr_t      [`XBAR_SLAVE_NUM-1:0]       s_awaddr;
    len_t       [`XBAR_SLAVE_NUM-1:0]       s_awlen;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_wvalid;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_wready;
    data_t      [`XBAR_SLAVE_NUM-1:0]       s_wdata;
    strb_t      [`XBAR_SLAVE_NUM-1:0]       s_wstrb;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_wlast;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_bvalid = '0;
    logic       [`XBAR_SLAVE_NUM-1:0]       s_bready;
    ext_id_t    [`XBAR_SLAVE_NUM-1:0]       s_bid = '0;
    resp_t      [`XBAR_SLAVE_NUM-1:0]       s_bresp = '0;

    // slave model state
    ext_id_t    [`XBAR_SLAVE_NUM-1:0]       last_awid = '0;
    resp_t      [`XBAR_SLAVE_NUM-1:0]       resp_value;

    axi_write_xbar dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // slave models answer each completed burst with one B
    always @(posedge clk) begin
        if (rst) begin
            s_bvalid  <= '0;
            last_awid <= '0;
        end else begin
            for (int s = 0; s < `XBAR_SLAVE_NUM; s++) begin
                if (s_awvalid[s] && s_awready[s])
                    last_awid[s] <= s_awid[s];
                if (s_bvalid[s] && s_bready[s])
                    s_bvalid[s] <= 1'b0;
                if (s_wvalid[s] && s_wready[s] && s_wlast[s]) begin
                    s_bvalid[s] <= 1'b1;
                    s_bid[s]    <= last_awid[s];
                    s_bresp[s]  <= resp_value[s];
                end
            end
        end
    end

    initial begin
        #(TEST_NUM * 200 * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", TEST_NUM * 200);
        stop_run();
    end

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_id(input string name, input ext_id_t got, input ext_id_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_plain_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // master number goes in front of the master's own id
    function automatic ext_id_t widen_id(input int m, input id_t id);
        return ext_id_t'((m << `XBAR_ID_LEN) | int'(id));
    endfunction

    function automatic addr_t addr_for(input int s);
        addr_t a;
        a = addr_t'($urandom);
        a[`XBAR_SEL_BIT] = s[0];
        return a;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        m_awvalid <= '0;
        m_wvalid  <= '0;
        m_wlast   <= '0;
        m_bready  <= '1;
        s_awready <= '1;
        s_wready  <= '1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic drive_aw(input int m, input addr_t addr, input id_t id, input len_t len);
        m_awvalid[m] <= 1'b1;
        m_awaddr[m]  <= addr;
        m_awid[m]    <= id;
        m_awlen[m]   <= len;
    endtask

    // entered at a falling edge and left just after the handshake edge
    task automatic wait_aw_accept(input int m);
        while (!m_awready[m])
            @(negedge clk);
        @(posedge clk);
        m_awvalid[m] <= 1'b0;
    endtask

    task automatic send_aw(input int m, input addr_t addr, input id_t id, input len_t len);
        @(posedge clk);
        drive_aw(m, addr, id, len);
        @(negedge clk);
        wait_aw_accept(m);
    endtask

    // beats of master m must show up on slave s only
    task automatic write_burst(input int m, input int s, input int beats);
        data_t data;
        strb_t strb;
        for (int i = 0; i < beats; i++) begin
            data = data_t'($urandom);
            strb = strb_t'($urandom);
            @(posedge clk);
            m_wvalid[m] <= 1'b1;
            m_wdata[m]  <= data;
            m_wstrb[m]  <= strb;
            m_wlast[m]  <= (i == beats - 1);
            @(negedge clk);
            while (!m_wready[m])
                @(negedge clk);
            check_flag($sformatf("s_wvalid[%0d]", s), s_wvalid[s], 1'b1);
            check_flag($sformatf("s_wvalid[%0d]", 1 - s), s_wvalid[1 - s], 1'b0);
            check_data($sformatf("s_wdata[%0d]", s), s_wdata[s], data);
            check_strb($sformatf("s_wstrb[%0d]", s), s_wstrb[s], strb);
            check_flag($sformatf("s_wlast[%0d]", s), s_wlast[s], i == beats - 1);
        end
        @(posedge clk);
        m_wvalid[m] <= 1'b0;
        m_wlast[m]  <= 1'b0;
    endtask

    task automatic wait_b(input int m);
        @(negedge clk);
        while (!m_bvalid[m])
            @(negedge clk);
    endtask

    task automatic test_decode();
        id_t   id;
        addr_t addr;
        len_t  len;
        apply_reset();
        for (int m = 0; m < `XBAR_MASTER_NUM; m++) begin
            for (int s = 0; s < `XBAR_SLAVE_NUM; s++) begin
                id   = id_t'($urandom);
                addr = addr_for(s);
                len  = len_t'($urandom);
                @(posedge clk);
                drive_aw(m, addr, id, len);
                @(negedge clk);
                check_flag($sformatf("s_awvalid[%0d]", s), s_awvalid[s], 1'b1);
                check_flag($sformatf("s_awvalid[%0d]", 1 - s), s_awvalid[1 - s], 1'b0);
                check_id($sformatf("s_awid[%0d]", s), s_awid[s], widen_id(m, id));
                check_addr($sformatf("s_awaddr[%0d]", s), s_awaddr[s], addr);
                check_len($sformatf("s_awlen[%0d]", s), s_awlen[s], len);
                wait_aw_accept(m);
            end
        end
    endtask

    task automatic test_w_order();
        apply_reset();
        send_aw(0, addr_for(1), id_t'($urandom), 8'd1);
        send_aw(0, addr_for(0), id_t'($urandom), 8'd2);
        write_burst(0, 1, 2);
        write_burst(0, 0, 3);
    endtask

    task automatic test_b_route();
        id_t   id;
        resp_t resp;
        int    s;
        apply_reset();
        for (int m = 0; m < `XBAR_MASTER_NUM; m++) begin
            // the BID head and not the slave number must pick the master
            s    = 1 - m;
            id   = id_t'($urandom);
            resp = resp_t'($urandom);
            resp_value[s] <= resp;
            send_aw(m, addr_for(s), id, 8'd0);
            write_burst(m, s, 1);
            wait_b(m);
            check_flag($sformatf("m_bvalid[%0d]", 1 - m), m_bvalid[1 - m], 1'b0);
            check_plain_id($sformatf("m_bid[%0d]", m), m_bid[m], id);
            check_resp($sformatf("m_bresp[%0d]", m), m_bresp[m], resp);
            check_flag($sformatf("s_bready[%0d]", s), s_bready[s], 1'b1);
            check_flag($sformatf("s_bready[%0d]", 1 - s), s_bready[1 - s], 1'b0);
            @(posedge clk);
        end
    endtask

    task automatic test_priority();
        id_t id0;
        id_t id1;
        id0 = id_t'($urandom);
        id1 = id_t'($urandom);
        apply_reset();
        @(posedge clk);
        drive_aw(0, addr_for(0), id0, 8'd0);
        drive_aw(1, addr_for(0), id1, 8'd0);
        @(negedge clk);
        check_flag("m_awready[0]", m_awready[0], 1'b1);
        check_flag("m_awready[1]", m_awready[1], 1'b0);
        check_id("s_awid[0]", s_awid[0], widen_id(0, id0));
        // master 0 asks again and master 1 must win after the rotation
        @(posedge clk);
        drive_aw(0, addr_for(0), id0, 8'd0);
        @(negedge clk);
        check_flag("m_awready[1]", m_awready[1], 1'b1);
        check_flag("m_awready[0]", m_awready[0], 1'b0);
        check_id("s_awid[0]", s_awid[0], widen_id(1, id1));
        @(posedge clk);
        m_awvalid[1] <= 1'b0;
        @(negedge clk);
        check_flag("m_awready[0]", m_awready[0], 1'b1);
        @(posedge clk);
        m_awvalid[0] <= 1'b0;
    endtask

    task automatic test_backpressure();
        id_t id;
        id = id_t'($urandom);
        apply_reset();
        s_awready[0] <= 1'b0;
        @(posedge clk);
        drive_aw(0, addr_for(0), id, 8'd0);
        repeat (3) begin
            @(negedge clk);
            check_flag("s_awvalid[0]", s_awvalid[0], 1'b1);
            check_flag("m_awready[0]", m_awready[0], 1'b0);
            check_id("s_awid[0]", s_awid[0], widen_id(0, id));
        end
        @(posedge clk);
        s_awready[0] <= 1'b1;
        @(negedge clk);
        check_flag("m_awready[0]", m_awready[0], 1'b1);
        wait_aw_accept(0);
        // fill the order queue of master 0
        for (int i = 1; i < `XBAR_W_BUF_DEPTH; i++)
            send_aw(0, addr_for(1), id_t'($urandom), 8'd0);
        @(posedge clk);
        drive_aw(0, addr_for(1), id, 8'd0);
        repeat (3) begin
            @(negedge clk);
            check_flag("m_awready[0]", m_awready[0], 1'b0);
            check_flag("s_awvalid[1]", s_awvalid[1], 1'b0);
        end
        write_burst(0, 0, 1);
        @(negedge clk);
        check_flag("m_awready[0]", m_awready[0], 1'b1);
        wait_aw_accept(0);
    endtask

    initial begin
        void'($urandom(32'h768f));
        rst        = 1'b0;
        m_awvalid  = '0;
        m_awid     = '0;
        m_awaddr   = '0;
        m_awlen    = '0;
        m_wvalid   = '0;
        m_wdata    = '0;
        m_wstrb    = '0;
        m_wlast    = '0;
        m_bready   = '1;
        s_awready  = '1;
        s_wready   = '1;
        resp_value = '0;
        test_decode();
        test_w_order();
        test_b_route();
        test_priority();
        test_backpressure();
        repeat (2) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/axi_write_xbar.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defs.svh"

module axi_write_xbar
    import axi_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,

    // masters
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_awvalid,
    output logic        [`XBAR_MASTER_NUM-1:0]  m_awready,
    input  id_t         [`XBAR_MASTER_NUM-1:0]  m_awid,
    input  addr_t       [`XBAR_MASTER_NUM-1:0]  m_awaddr,
    input  len_t        [`XBAR_MASTER_NUM-1:0]  m_awlen,
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_wvalid,
    output logic        [`XBAR_MASTER_NUM-1:0]  m_wready,
    input  data_t       [`XBAR_MASTER_NUM-1:0]  m_wdata,
    input  strb_t       [`XBAR_MASTER_NUM-1:0]  m_wstrb,
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_wlast,
    output logic        [`XBAR_MASTER_NUM-1:0]  m_bvalid,
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_bready,
    output id_t         [`XBAR_MASTER_NUM-1:0]  m_bid,
    output resp_t       [`XBAR_MASTER_NUM-1:0]  m_bresp,

    // slaves
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_awvalid,
    input  logic        [`XBAR_SLAVE_NUM-1:0]   s_awready,
    output ext_id_t     [`XBAR_SLAVE_NUM-1:0]   s_awid,
    output addr_t       [`XBAR_SLAVE_NUM-1:0]   s_awaddr,
    output len_t        [`XBAR_SLAVE_NUM-1:0]   s_awlen,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_wvalid,
    input  logic        [`XBAR_SLAVE_NUM-1:0]   s_wready,
    output data_t       [`XBAR_SLAVE_NUM-1:0]   s_wdata,
    output strb_t       [`XBAR_SLAVE_NUM-1:0]   s_wstrb,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_wlast,
    input  logic        [`XBAR_SLAVE_NUM-1:0]   s_bvalid,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_bready,
    input  ext_id_t     [`XBAR_SLAVE_NUM-1:0]   s_bid,
    input  resp_t       [`XBAR_SLAVE_NUM-1:0]   s_bresp
);

    slave_sel_t  [`XBAR_MASTER_NUM-1:0] aw_req;
    slave_sel_t  [`XBAR_MASTER_NUM-1:0] aw_grant;
    slave_sel_t  [`XBAR_MASTER_NUM-1:0] aw_push_sel;
    slave_sel_t  [`XBAR_MASTER_NUM-1:0] w_req;
    slave_sel_t  [`XBAR_MASTER_NUM-1:0] w_grant;
    master_sel_t [`XBAR_SLAVE_NUM-1:0]  b_req;
    master_sel_t [`XBAR_SLAVE_NUM-1:0]  b_grant;
    logic        [`XBAR_MASTER_NUM-1:0] w_full;
    logic        [`XBAR_MASTER_NUM-1:0] aw_fire;
    logic        [`XBAR_MASTER_NUM-1:0] w_fire;
    logic        [`XBAR_SLAVE_NUM-1:0]  b_fire;

    assign aw_fire = m_awvalid & m_awready;
    // W pointer moves once per burst so bursts never interleave at a slave
    assign w_fire  = m_wvalid & m_wready & m_wlast;
    assign b_fire  = s_bvalid & s_bready;

    xbar_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .aw_req   (aw_req),
        .w_req    (w_req),
        .b_req    (b_req),
        .aw_fire  (aw_fire),
        .w_fire   (w_fire),
        .b_fire   (b_fire),
        .aw_grant (aw_grant),
        .w_grant  (w_grant),
        .b_grant  (b_grant)
    );

    aw_route u_aw_route (
        .m_awvalid   (m_awvalid),
        .m_awid      (m_awid),
        .m_awaddr    (m_awaddr),
        .m_awlen     (m_awlen),
        .s_awready   (s_awready),
        .aw_grant    (aw_grant),
        .w_full      (w_full),
        .aw_req      (aw_req),
        .aw_push_sel (aw_push_sel),
        .m_awready   (m_awready),
        .s_awvalid   (s_awvalid),
        .s_awid      (s_awid),
        .s_awaddr    (s_awaddr),
        .s_awlen     (s_awlen)
    );

    w_route u_w_route (
        .clk         (clk),
        .rst         (rst),
        .aw_push     (aw_fire),
        .aw_push_sel (aw_push_sel),
        .m_wvalid    (m_wvalid),
        .m_wdata     (m_wdata),
        .m_wstrb     (m_wstrb),
        .m_wlast     (m_wlast),
        .s_wready    (s_wready),
        .w_grant     (w_grant),
        .w_full      (w_full),
        .w_req       (w_req),
        .m_wready    (m_wready),
        .s_wvalid    (s_wvalid),
        .s_wdata     (s_wdata),
        .s_wstrb     (s_wstrb),
        .s_wlast     (s_wlast)
    );

    b_route u_b_route (
        .s_bvalid (s_bvalid),
        .s_bid    (s_bid),
        .s_bresp  (s_bresp),
        .m_bready (m_bready),
        .b_grant  (b_grant),
        .b_req    (b_req),
        .s_bready (s_bready),
        .m_bvalid (m_bvalid),
        .m_bid    (m_bid),
        .m_bresp  (m_bresp)
    );

endmodule

`default_nettype wire

// File: logic/b_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defs.svh"

module b_route
    import axi_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic        [`XBAR_SLAVE_NUM-1:0]   s_bvalid,
    input  ext_id_t     [`XBAR_SLAVE_NUM-1:0]   s_bid,
    input  resp_t       [`XBAR_SLAVE_NUM-1:0]   s_bresp,
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_bready,
    input  master_sel_t [`XBAR_SLAVE_NUM-1:0]   b_grant,
    output master_sel_t [`XBAR_SLAVE_NUM-1:0]   b_req,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_bready,
    output logic        [`XBAR_MASTER_NUM-1:0]  m_bvalid,
    output id_t         [`XBAR_MASTER_NUM-1:0]  m_bid,
    output resp_t       [`XBAR_MASTER_NUM-1:0]  m_bresp
);

    logic [`XBAR_SLAVE_NUM-1:0][`XBAR_EXTRA_ID_LEN-1:0] bid_head;
    id_t  [`XBAR_SLAVE_NUM-1:0]                         bid_plain;

    for (genvar s = 0; s < `XBAR_SLAVE_NUM; s++) begin : g_slave
        // head names the master, rest is the master's own id
        assign {bid_head[s], bid_plain[s]} = s_bid[s];

        assign b_req[s] = s_bvalid[s] ? (master_sel_t'(1) << bid_head[s]) : '0;

        assign s_bready[s] = |(b_grant[s] & m_bready);
    end

    always_comb begin
        m_bvalid = '0;
        m_bid    = '0;
        m_bresp  = '0;
        for (int m = 0; m < `XBAR_MASTER_NUM; m++) begin
            for (int s = 0; s < `XBAR_SLAVE_NUM; s++) begin
                if (b_grant[s][m]) begin
                    m_bvalid[m] = s_bvalid[s];
                    m_bid[m]    = bid_plain[s];
                    m_bresp[m]  = s_bresp[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/w_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defs.svh"

module w_route
    import axi_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  logic        [`XBAR_MASTER_NUM-1:0]  aw_push,
    input  slave_sel_t  [`XBAR_MASTER_NUM-1:0]  aw_push_sel,
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_wvalid,
    input  data_t       [`XBAR_MASTER_NUM-1:0]  m_wdata,
    input  strb_t       [`XBAR_MASTER_NUM-1:0]  m_wstrb,
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_wlast,
    input  logic        [`XBAR_SLAVE_NUM-1:0]   s_wready,
    input  slave_sel_t  [`XBAR_MASTER_NUM-1:0]  w_grant,
    output logic        [`XBAR_MASTER_NUM-1:0]  w_full,
    output slave_sel_t  [`XBAR_MASTER_NUM-1:0]  w_req,
    output logic        [`XBAR_MASTER_NUM-1:0]  m_wready,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_wvalid,
    output data_t       [`XBAR_SLAVE_NUM-1:0]   s_wdata,
    output strb_t       [`XBAR_SLAVE_NUM-1:0]   s_wstrb,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_wlast
);

    localparam int DEPTH = `XBAR_W_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`XBAR_MASTER_NUM-1:0] pop;

    for (genvar m = 0; m < `XBAR_MASTER_NUM; m++) begin : g_queue
        // slaves of accepted AWs, oldest at rd_ptr
        slave_sel_t       order_mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;

        assign m_wready[m] = |(w_grant[m] & s_wready);
        assign pop[m]      = m_wvalid[m] & m_wready[m] & m_wlast[m];
        assign w_full[m]   = (count == CNT_W'(DEPTH));
        assign w_req[m]    = (count != '0) ? order_mem[rd_ptr] : '0;

        always_ff @(posedge clk) begin
            if (aw_push[m])
                order_mem[wr_ptr] <= aw_push_sel[m];
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (aw_push[m])
                    wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                if (pop[m])
                    rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                case ({aw_push[m], pop[m]})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    // granted master's beat to each slave
    always_comb begin
        s_wvalid = '0;
        s_wdata  = '0;
        s_wstrb  = '0;
        s_wlast  = '0;
        for (int s = 0; s < `XBAR_SLAVE_NUM; s++) begin
            for (int m = 0; m < `XBAR_MASTER_NUM; m++) begin
                if (w_grant[m][s]) begin
                    s_wvalid[s] = m_wvalid[m];
                    s_wdata[s]  = m_wdata[m];
                    s_wstrb[s]  = m_wstrb[m];
                    s_wlast[s]  = m_wlast[m];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/aw_route.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defs.svh"

module aw_route
    import axi_pkg::*;
    import xbar_route_pkg::*;
(
    input  logic        [`XBAR_MASTER_NUM-1:0]  m_awvalid,
    input  id_t         [`XBAR_MASTER_NUM-1:0]  m_awid,
    input  addr_t       [`XBAR_MASTER_NUM-1:0]  m_awaddr,
    input  len_t        [`XBAR_MASTER_NUM-1:0]  m_awlen,
    input  logic        [`XBAR_SLAVE_NUM-1:0]   s_awready,
    input  slave_sel_t  [`XBAR_MASTER_NUM-1:0]  aw_grant,
    input  logic        [`XBAR_MASTER_NUM-1:0]  w_full,
    output slave_sel_t  [`XBAR_MASTER_NUM-1:0]  aw_req,
    output slave_sel_t  [`XBAR_MASTER_NUM-1:0]  aw_push_sel,
    output logic        [`XBAR_MASTER_NUM-1:0]  m_awready,
    output logic        [`XBAR_SLAVE_NUM-1:0]   s_awvalid,
    output ext_id_t     [`XBAR_SLAVE_NUM-1:0]   s_awid,
    output addr_t       [`XBAR_SLAVE_NUM-1:0]   s_awaddr,
    output len_t        [`XBAR_SLAVE_NUM-1:0]   s_awlen
);

    ext_id_t [`XBAR_MASTER_NUM-1:0] awid_ext;

    for (genvar m = 0; m < `XBAR_MASTER_NUM; m++) begin : g_master
        localparam logic [`XBAR_EXTRA_ID_LEN-1:0] MASTER_HEAD = (`XBAR_EXTRA_ID_LEN)'(m);

        // address decode, one slave per region
        assign aw_push_sel[m] = slave_sel_t'(1) << m_awaddr[m][`XBAR_SEL_BIT];

        // no request while the W order queue has no room
        assign aw_req[m] = (m_awvalid[m] && !w_full[m]) ? aw_push_sel[m] : '0;

        assign awid_ext[m] = {MASTER_HEAD, m_awid[m]};

        assign m_awready[m] = |(aw_grant[m] & s_awready);
    end

    // granted master drives each slave
    always_comb begin
        s_awvalid = '0;
        s_awid    = '0;
        s_awaddr  = '0;
        s_awlen   = '0;
        for (int s = 0; s < `XBAR_SLAVE_NUM; s++) begin
            for (int m = 0; m < `XBAR_MASTER_NUM; m++) begin
                if (aw_grant[m][s]) begin
                    s_awvalid[s] = m_awvalid[m];
                    s_awid[s]    = awid_ext[m];
                    s_awaddr[s]  = m_awaddr[m];
                    s_awlen[s]   = m_awlen[m];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/xbar_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "xbar_defs.svh"

module xbar_arbiter
    import xbar_route_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    input  slave_sel_t  [`XBAR_MASTER_NUM-1:0]  aw_req,
    input  slave_sel_t  [`XBAR_MASTER_NUM-1:0]  w_req,
    input  master_sel_t [`XBAR_SLAVE_NUM-1:0]   b_req,
    input  logic        [`XBAR_MASTER_NUM-1:0]  aw_fire,
    input  logic        [`XBAR_MASTER_NUM-1:0]  w_fire,
    input  logic        [`XBAR_SLAVE_NUM-1:0]   b_fire,
    output slave_sel_t  [`XBAR_MASTER_NUM-1:0]  aw_grant,
    output slave_sel_t  [`XBAR_MASTER_NUM-1:0]  w_grant,
    output master_sel_t [`XBAR_SLAVE_NUM-1:0]   b_grant
);

    localparam int MASTER_NUM = `XBAR_MASTER_NUM;
    localparam int SLAVE_NUM  = `XBAR_SLAVE_NUM;
    localparam int SEND_MAX   = (MASTER_NUM > SLAVE_NUM) ? MASTER_NUM : SLAVE_NUM;

    typedef logic [SEND_MAX-1:0] send_vec_t;

    // one pointer per target: slaves for AW and W, masters for B
    prio_state_t aw_ptr [SLAVE_NUM];
    prio_state_t w_ptr  [SLAVE_NUM];
    prio_state_t b_ptr  [MASTER_NUM];

    // first requester at or above the pointer, wrapping at n
    function automatic send_vec_t rr_pick(input send_vec_t req, input prio_state_t ptr,
                                          input int n);
        send_vec_t gnt;
        int        idx;
        gnt = '0;
        for (int k = 0; k < SEND_MAX; k++) begin
            idx = int'(ptr) + k;
            if (idx >= n)
                idx = idx - n;
            if (k < n && gnt == '0 && req[idx])
                gnt[idx] = 1'b1;
        end
        return gnt;
    endfunction

    function automatic prio_state_t next_prio(input int k, input int n);
        return (k + 1 == n) ? PRIO_SENDER_0 : prio_state_t'(k + 1);
    endfunction

    always_comb begin
        send_vec_t col;
        send_vec_t gnt;
        aw_grant = '0;
        w_grant  = '0;
        b_grant  = '0;
        for (int s = 0; s < SLAVE_NUM; s++) begin
            col = '0;
            for (int m = 0; m < MASTER_NUM; m++)
                col[m] = aw_req[m][s];
            gnt = rr_pick(col, aw_ptr[s], MASTER_NUM);
            for (int m = 0; m < MASTER_NUM; m++)
                aw_grant[m][s] = gnt[m];

            col = '0;
            for (int m = 0; m < MASTER_NUM; m++)
                col[m] = w_req[m][s];
            gnt = rr_pick(col, w_ptr[s], MASTER_NUM);
            for (int m = 0; m < MASTER_NUM; m++)
                w_grant[m][s] = gnt[m];
        end
        // slaves compete for each master on B
        for (int m = 0; m < MASTER_NUM; m++) begin
            col = '0;
            for (int s = 0; s < SLAVE_NUM; s++)
                col[s] = b_req[s][m];
            gnt = rr_pick(col, b_ptr[m], SLAVE_NUM);
            for (int s = 0; s < SLAVE_NUM; s++)
                b_grant[s][m] = gnt[s];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SLAVE_NUM; s++) begin
                aw_ptr[s] <= PRIO_SENDER_0;
                w_ptr[s]  <= PRIO_SENDER_0;
            end
            for (int m = 0; m < MASTER_NUM; m++)
                b_ptr[m] <= PRIO_SENDER_0;
        end else begin
            for (int s = 0; s < SLAVE_NUM; s++) begin
                for (int m = 0; m < MASTER_NUM; m++) begin
                    if (aw_fire[m] && aw_grant[m][s])
                        aw_ptr[s] <= next_prio(m, MASTER_NUM);
                    if (w_fire[m] && w_grant[m][s])
                        w_ptr[s] <= next_prio(m, MASTER_NUM);
                end
            end
            for (int m = 0; m < MASTER_NUM; m++) begin
                for (int s = 0; s < SLAVE_NUM; s++) begin
                    if (b_fire[s] && b_grant[s][m])
                        b_ptr[m] <= next_prio(s, SLAVE_NUM);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/xbar_route_pkg.sv
`default_nettype none

`include "xbar_defs.svh"

package xbar_route_pkg;

    // one-hot target choices
    typedef logic [`XBAR_SLAVE_NUM-1:0]  slave_sel_t;
    typedef logic [`XBAR_MASTER_NUM-1:0] master_sel_t;

    // sender that currently has highest priority at one target
    typedef enum logic [0:0] {
        PRIO_SENDER_0 = 1'b0,
        PRIO_SENDER_1 = 1'b1
    } prio_state_t;

endpackage

`default_nettype wire

// File: logic/axi_pkg.sv
`default_nettype none

`include "xbar_defs.svh"

package axi_pkg;

    // master side fields
    typedef logic [`XBAR_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`XBAR_DATA_WIDTH-1:0]   data_t;
    typedef logic [`XBAR_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [7:0]                    len_t;
    typedef logic [1:0]                    resp_t;
    typedef logic [`XBAR_ID_LEN-1:0]       id_t;

    // slave side id, master number in the top bits
    typedef logic [`XBAR_EXTRA_ID_LEN+`XBAR_ID_LEN-1:0] ext_id_t;

endpackage

`default_nettype wire

// File: logic/xbar_defs.svh
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// crossbar size
`define XBAR_MASTER_NUM      2
`define XBAR_SLAVE_NUM       2

// bus widths
`define XBAR_ADDR_WIDTH      32
`define XBAR_DATA_WIDTH      32

// master side id, and the master number put in front of it
`define XBAR_ID_LEN          4
`define XBAR_EXTRA_ID_LEN    1

// outstanding AW per master waiting for W
`define XBAR_W_BUF_DEPTH     4

// address bit that picks the slave
`define XBAR_SEL_BIT         28

`endif
